/* common/decodePkg.sv */
/*
 * Decode stage package with widths, opcode and function codes,
 * instruction field positions and the banked stack-pointer mapping
 */
`default_nettype none

package decodePkg;

	// ========================================================================
	// Widths
	// ========================================================================

	localparam int INSN_W = 32;
	// Architectural specifiers reach past 31 for the banked stack pointers
	localparam int AREG_W = 6;
	localparam int FLD_W = 5;
	localparam int IMM_W = 32;

	// Field value naming the stack pointer, and the first banked slot
	localparam logic [FLD_W-1:0] SP_FLD = 5'd31;
	localparam logic [AREG_W-1:0] SP_BASE = 6'd32;

	// ========================================================================
	// Instruction field positions
	// ========================================================================

	localparam int OPC_LSB = 0;
	localparam int OPC_W = 7;
	localparam int RT_LSB = 7;
	localparam int RA_LSB = 12;
	localparam int RB_LSB = 17;
	localparam int RC_LSB = 22;
	localparam int FUNC_LSB = 27;
	localparam int FUNC_W = 3;
	localparam int RCN_BIT = 30;
	localparam int RTN_BIT = 31;
	// The immediate overlays rb, rc, func and both negate bits
	localparam int IMMF_LSB = 17;
	localparam int IMMF_W = 15;

	// ========================================================================
	// Codes
	// ========================================================================

	typedef enum logic [1:0] {
		MODE_USER = 2'd0,
		MODE_SUPER = 2'd1,
		MODE_HYPER = 2'd2,
		MODE_MACHINE = 2'd3
	} opModeE;

	typedef enum logic [6:0] {
		OP_NOP = 7'd0,
		OP_R2 = 7'd2,
		OP_SHIFT = 7'd3,
		OP_ADDI = 7'd4,
		OP_ADDSI = 7'd5,
		OP_ORSI = 7'd6,
		OP_LDO = 7'd16,
		OP_STB = 7'd24,
		OP_STO = 7'd27,
		OP_STX = 7'd28
	} opcodeE;

	// Store functions apply under OP_STX, shift functions under OP_SHIFT
	typedef enum logic [2:0] {
		FN_STX = 3'd0,
		FN_STCTX = 3'd1,
		FN_SHL = 3'd2,
		FN_SHR = 3'd3,
		FN_SHLI = 3'd4,
		FN_SHRI = 3'd5
	} funcE;

	// Register 31 is banked per mode, everything else is zero-extended
	function automatic logic [AREG_W-1:0] spMap(
		input logic [FLD_W-1:0] fld,
		input opModeE mode
	);
		logic [AREG_W-1:0] res;
		if (fld == SP_FLD)
			res = SP_BASE + AREG_W'(mode);
		else
			res = AREG_W'(fld);
		return res;
	endfunction

endpackage

`default_nettype wire

/* decode/decodeCtrl.sv */
/*
 * Decode control holding the stage-1 instruction register,
 * both stage-valid bits and the stage-2 load enable
 */
`timescale 1ns/1ps
`default_nettype none

module decodeCtrl (
	input wire logic clk,
	input wire logic rstN,
	input wire logic insValid,
	input wire logic [decodePkg::INSN_W-1:0] insn,
	input decodePkg::opModeE om,
	input wire logic stall,
	input wire logic flush,
	output logic [decodePkg::INSN_W-1:0] insnQ,
	output decodePkg::opModeE omQ,
	output logic outLoad,
	output logic decValid
);

	// Stage-1 valid, set when an instruction sits in insnQ
	logic v1;

	// Flush beats stall, and stall freezes both stages
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			v1 <= 1'b0;
			decValid <= 1'b0;
		end
		else if (flush)
		begin
			v1 <= 1'b0;
			decValid <= 1'b0;
		end
		else if (!stall)
		begin
			v1 <= insValid;
			decValid <= v1;
		end
	end

	// Only a valid instruction overwrites the held word
	always_ff @(posedge clk)
	begin
		if (!stall && insValid)
		begin
			insnQ <= insn;
			omQ <= om;
		end
	end

	// A flushed instruction must not reach the decoded outputs either
	assign outLoad = v1 & ~stall & ~flush;

endmodule

`default_nettype wire

/* decode/decodeRab.sv */
/*
 * Source register Ra and Rb decoder with stack mapping and zero flags
 */
`timescale 1ns/1ps
`default_nettype none

module decodeRab (
	input wire logic clk,
	input wire logic rstN,
	input wire logic outLoad,
	input wire logic [decodePkg::INSN_W-1:0] insnQ,
	input decodePkg::opModeE omQ,
	output logic [decodePkg::AREG_W-1:0] ra,
	output logic raz,
	output logic [decodePkg::AREG_W-1:0] rb,
	output logic rbz
);

	decodePkg::opcodeE opc;
	decodePkg::funcE fn;
	logic [decodePkg::AREG_W-1:0] raNext;
	logic [decodePkg::AREG_W-1:0] rbNext;

	always_comb
	begin
		opc = decodePkg::opcodeE'(insnQ[decodePkg::OPC_LSB +: decodePkg::OPC_W]);
		fn = decodePkg::funcE'(insnQ[decodePkg::FUNC_LSB +: decodePkg::FUNC_W]);
		// Every opcode reads Ra
		raNext = decodePkg::spMap(insnQ[decodePkg::RA_LSB +: decodePkg::FLD_W], omQ);
		rbNext = '0;
		case (opc)
			decodePkg::OP_R2,
			decodePkg::OP_STX:
				rbNext = decodePkg::spMap(insnQ[decodePkg::RB_LSB +: decodePkg::FLD_W], omQ);
			// Shift by register only, the immediate forms reuse the rb bits
			decodePkg::OP_SHIFT:
				if (fn == decodePkg::FN_SHL || fn == decodePkg::FN_SHR)
					rbNext = decodePkg::spMap(insnQ[decodePkg::RB_LSB +: decodePkg::FLD_W], omQ);
			default:
				rbNext = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			ra <= '0;
			raz <= 1'b0;
			rb <= '0;
			rbz <= 1'b0;
		end
		else if (outLoad)
		begin
			ra <= raNext;
			raz <= (raNext == '0);
			rb <= rbNext;
			rbz <= (rbNext == '0);
		end
	end

endmodule

`default_nettype wire

/* decode/decodeRc.sv */
/*
 * Third source register decoder with its negate and zero flags
 */
`timescale 1ns/1ps
`default_nettype none

module decodeRc (
	input wire logic clk,
	input wire logic rstN,
	input wire logic outLoad,
	input wire logic [decodePkg::INSN_W-1:0] insnQ,
	input decodePkg::opModeE omQ,
	input wire logic immC,
	output logic [decodePkg::AREG_W-1:0] rc,
	output logic rcz,
	output logic rcn
);

	decodePkg::opcodeE opc;
	decodePkg::funcE fn;
	logic [decodePkg::FLD_W-1:0] fld;
	logic forceZero;
	logic rcnNext;
	logic [decodePkg::AREG_W-1:0] rcNext;

	always_comb
	begin
		opc = decodePkg::opcodeE'(insnQ[decodePkg::OPC_LSB +: decodePkg::OPC_W]);
		fn = decodePkg::funcE'(insnQ[decodePkg::FUNC_LSB +: decodePkg::FUNC_W]);
		// The plain rc field is the usual source
		fld = insnQ[decodePkg::RC_LSB +: decodePkg::FLD_W];
		rcnNext = insnQ[decodePkg::RCN_BIT];
		forceZero = 1'b0;
		case (opc)
			// Store data and the short immediates take the third operand from rt
			decodePkg::OP_ADDSI,
			decodePkg::OP_ORSI,
			decodePkg::OP_STB,
			decodePkg::OP_STO:
			begin
				fld = insnQ[decodePkg::RT_LSB +: decodePkg::FLD_W];
				rcnNext = insnQ[decodePkg::RTN_BIT];
			end
			decodePkg::OP_R2,
			decodePkg::OP_SHIFT:
				rcnNext = insnQ[decodePkg::RCN_BIT];
			// Context stores never negate
			decodePkg::OP_STX:
				if (fn == decodePkg::FN_STCTX)
					rcnNext = 1'b0;
			// The immediate covers the rc bits, so no register is read
			default:
				if (immC)
				begin
					forceZero = 1'b1;
					rcnNext = 1'b0;
				end
		endcase
		rcNext = forceZero ? '0 : decodePkg::spMap(fld, omQ);
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			rc <= '0;
			rcz <= 1'b0;
			rcn <= 1'b0;
		end
		else if (outLoad)
		begin
			rc <= rcNext;
			rcz <= (rcNext == '0);
			rcn <= rcnNext;
		end
	end

endmodule

`default_nettype wire

/* decode/decodeRt.sv */
/*
 * Target register decoder with write enable
 */
`timescale 1ns/1ps
`default_nettype none

module decodeRt (
	input wire logic clk,
	input wire logic rstN,
	input wire logic outLoad,
	input wire logic [decodePkg::INSN_W-1:0] insnQ,
	input decodePkg::opModeE omQ,
	output logic [decodePkg::AREG_W-1:0] rt,
	output logic rtWe
);

	decodePkg::opcodeE opc;
	logic [decodePkg::AREG_W-1:0] rtNext;

	always_comb
	begin
		opc = decodePkg::opcodeE'(insnQ[decodePkg::OPC_LSB +: decodePkg::OPC_W]);
		case (opc)
			decodePkg::OP_R2,
			decodePkg::OP_SHIFT,
			decodePkg::OP_ADDI,
			decodePkg::OP_ADDSI,
			decodePkg::OP_ORSI,
			decodePkg::OP_LDO:
				rtNext = decodePkg::spMap(insnQ[decodePkg::RT_LSB +: decodePkg::FLD_W], omQ);
			// Stores use the rt bits as a source, so nothing is written
			decodePkg::OP_NOP,
			decodePkg::OP_STB,
			decodePkg::OP_STO,
			decodePkg::OP_STX:
				rtNext = '0;
			default:
				rtNext = '0;
		endcase
	end

	// Register zero swallows writes
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			rt <= '0;
			rtWe <= 1'b0;
		end
		else if (outLoad)
		begin
			rt <= rtNext;
			rtWe <= (rtNext != '0);
		end
	end

endmodule

`default_nettype wire

/* decode/decodeImm.sv */
/*
 * Immediate decoder with its flag and the Rc-slot-is-immediate indication
 */
`timescale 1ns/1ps
`default_nettype none

module decodeImm (
	input wire logic clk,
	input wire logic rstN,
	input wire logic outLoad,
	input wire logic [decodePkg::INSN_W-1:0] insnQ,
	output logic [decodePkg::IMM_W-1:0] imm,
	output logic hasImm,
	output logic immC
);

	decodePkg::opcodeE opc;
	decodePkg::funcE fn;
	logic [decodePkg::IMMF_W-1:0] immFld;
	logic [decodePkg::IMM_W-1:0] immNext;
	logic hasImmNext;

	always_comb
	begin
		opc = decodePkg::opcodeE'(insnQ[decodePkg::OPC_LSB +: decodePkg::OPC_W]);
		fn = decodePkg::funcE'(insnQ[decodePkg::FUNC_LSB +: decodePkg::FUNC_W]);
		immFld = insnQ[decodePkg::IMMF_LSB +: decodePkg::IMMF_W];
		immNext = '0;
		hasImmNext = 1'b0;
		case (opc)
			decodePkg::OP_ADDI,
			decodePkg::OP_ADDSI,
			decodePkg::OP_ORSI,
			decodePkg::OP_LDO,
			decodePkg::OP_STB,
			decodePkg::OP_STO:
			begin
				immNext = {{(decodePkg::IMM_W - decodePkg::IMMF_W){immFld[decodePkg::IMMF_W-1]}},
					immFld};
				hasImmNext = 1'b1;
			end
			// Shift amount lives in the rb field and is never signed
			decodePkg::OP_SHIFT:
				if (fn == decodePkg::FN_SHLI || fn == decodePkg::FN_SHRI)
				begin
					immNext = decodePkg::IMM_W'(insnQ[decodePkg::RB_LSB +: decodePkg::FLD_W]);
					hasImmNext = 1'b1;
				end
			default:
				hasImmNext = 1'b0;
		endcase
		// Only these two spread the immediate over the rc bits
		immC = (opc == decodePkg::OP_ADDI) || (opc == decodePkg::OP_LDO);
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			imm <= '0;
			hasImm <= 1'b0;
		end
		else if (outLoad)
		begin
			imm <= immNext;
			hasImm <= hasImmNext;
		end
	end

endmodule

`default_nettype wire

/* decode/decodeTop.sv */
/*
 * Register and immediate decode stage, two edges from insValid to decValid
 */
`timescale 1ns/1ps
`default_nettype none

module decodeTop (
	input wire logic clk,
	input wire logic rstN,
	input wire logic insValid,
	input wire logic [decodePkg::INSN_W-1:0] insn,
	input decodePkg::opModeE om,
	input wire logic stall,
	input wire logic flush,
	output logic decValid,
	output logic [decodePkg::AREG_W-1:0] ra,
	output logic raz,
	output logic [decodePkg::AREG_W-1:0] rb,
	output logic rbz,
	output logic [decodePkg::AREG_W-1:0] rc,
	output logic rcz,
	output logic rcn,
	output logic [decodePkg::AREG_W-1:0] rt,
	output logic rtWe,
	output logic [decodePkg::IMM_W-1:0] imm,
	output logic hasImm
);

	// ========================================================================
	// Stage 1 to stage 2 wiring
	// ========================================================================

	logic [decodePkg::INSN_W-1:0] insnQ;
	decodePkg::opModeE omQ;
	logic outLoad;
	// Immediate decoder tells Rc that its slot is taken
	logic immC;

	decodeCtrl uCtrl (
		.clk      (clk),
		.rstN     (rstN),
		.insValid (insValid),
		.insn     (insn),
		.om       (om),
		.stall    (stall),
		.flush    (flush),
		.insnQ    (insnQ),
		.omQ      (omQ),
		.outLoad  (outLoad),
		.decValid (decValid)
	);

	decodeRab uRab (.clk(clk), .rstN(rstN), .outLoad(outLoad), .insnQ(insnQ), .omQ(omQ),
		.ra(ra), .raz(raz), .rb(rb), .rbz(rbz));

	decodeRc uRc (.clk(clk), .rstN(rstN), .outLoad(outLoad), .insnQ(insnQ), .omQ(omQ),
		.immC(immC), .rc(rc), .rcz(rcz), .rcn(rcn));

	decodeRt uRt (.clk(clk), .rstN(rstN), .outLoad(outLoad), .insnQ(insnQ), .omQ(omQ),
		.rt(rt), .rtWe(rtWe));

	decodeImm uImm (.clk(clk), .rstN(rstN), .outLoad(outLoad), .insnQ(insnQ),
		.imm(imm), .hasImm(hasImm), .immC(immC));

endmodule

`default_nettype wire

/* verif/decode_assertions.sv */
/*
 * Timing assertions on the decode control block, bound into decodeCtrl
 */
`timescale 1ns/1ps
`default_nettype none

module decodeAssertions (
	input wire logic clk,
	input wire logic rstN,
	input wire logic stall,
	input wire logic flush,
	input wire logic v1,
	input wire logic decValid
);

	// Nothing decoded may appear while reset is held
	assert property (@(posedge clk) !rstN |=> !decValid)
		else $error("decValid high during reset");

	// Stage 2 valid is stage 1 valid one edge later when the pipe moves
	assert property (@(posedge clk) disable iff (!rstN)
		(!stall && !flush) |=> (decValid == $past(v1)))
		else $error("decValid did not follow v1");

	// A stall without a flush freezes both stages
	assert property (@(posedge clk) disable iff (!rstN)
		(stall && !flush) |=> ($stable(v1) && $stable(decValid)))
		else $error("stage valid bits moved during stall");

	// Flush wins over stall and empties stage 2
	assert property (@(posedge clk) disable iff (!rstN) flush |=> !decValid)
		else $error("decValid survived a flush");

endmodule

bind decodeCtrl decodeAssertions uAsserts (
	.clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
	.v1(v1), .decValid(decValid)
);

`default_nettype wire

/* verif/decodeTb.sv */
/*
 * Table-driven testbench for the decode stage, covering operand decode,
 * stall, flush and the fixed two-edge latency
 */
`timescale 1ns/1ps
`default_nettype none

module decodeTb;

	logic clk;
	logic rstN;
	logic insValid;
	logic [decodePkg::INSN_W-1:0] insn;
	decodePkg::opModeE om;
	logic stall;
	logic flush;
	logic decValid;
	logic [decodePkg::AREG_W-1:0] ra;
	logic raz;
	logic [decodePkg::AREG_W-1:0] rb;
	logic rbz;
	logic [decodePkg::AREG_W-1:0] rc;
	logic rcz;
	logic rcn;
	logic [decodePkg::AREG_W-1:0] rt;
	logic rtWe;
	logic [decodePkg::IMM_W-1:0] imm;
	logic hasImm;

	decodeTop UUT (
		.clk(clk), .rstN(rstN), .insValid(insValid), .insn(insn), .om(om),
		.stall(stall), .flush(flush), .decValid(decValid),
		.ra(ra), .raz(raz), .rb(rb), .rbz(rbz), .rc(rc), .rcz(rcz), .rcn(rcn),
		.rt(rt), .rtWe(rtWe), .imm(imm), .hasImm(hasImm)
	);

	// ========================================================================
	// Stimulus table with one entry per row in each queue
	// ========================================================================

	string rName[$];
	logic [31:0] rInsn[$];
	// Bits that no output depends on, refilled from the LFSR on every issue
	logic [31:0] rDc[$];
	decodePkg::opModeE rOm[$];
	bit rStall[$];
	bit rFlush[$];
	logic [5:0] rRa[$], rRb[$], rRc[$], rRt[$];
	// Flag order is raz, rbz, rcz, rcn, rtWe, hasImm from the top bit down
	logic [5:0] rFlags[$];
	logic [31:0] rImm[$];

	logic [31:0] lfsrState = 32'h23d9;
	// Row whose outputs the DUT should hold, or -1 for the reset values
	int prevIdx = -1;

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic addRow(input string name, input logic [31:0] w, input logic [31:0] dc,
		input decodePkg::opModeE mode, input bit stl, input bit fl, input logic [5:0] eRa,
		input logic [5:0] eRb, input logic [5:0] eRc, input logic [5:0] eRt,
		input logic [5:0] eFlags, input logic [31:0] eImm);
		rName.push_back(name);
		rInsn.push_back(w);
		rDc.push_back(dc);
		rOm.push_back(mode);
		rStall.push_back(stl);
		rFlush.push_back(fl);
		rRa.push_back(eRa);
		rRb.push_back(eRb);
		rRc.push_back(eRc);
		rRt.push_back(eRt);
		rFlags.push_back(eFlags);
		rImm.push_back(eImm);
	endtask

	// The register form leaves rtN at zero since no register form reads it
	function automatic logic [31:0] regInsn(input decodePkg::opcodeE op,
		input logic [4:0] fRt, input logic [4:0] fRa, input logic [4:0] fRb,
		input logic [4:0] fRc, input decodePkg::funcE fn, input logic rcN);
		return {1'b0, rcN, fn, fRc, fRb, fRa, fRt, op};
	endfunction

	// In the immediate form the top immediate bit doubles as rtN
	function automatic logic [31:0] immInsn(input decodePkg::opcodeE op,
		input logic [4:0] fRt, input logic [4:0] fRa, input logic [14:0] fImm);
		return {fImm, fRa, fRt, op};
	endfunction

	// Expected values follow the decode rules by hand where 31 maps to 32 plus the mode
	task automatic buildTable();
		addRow("r2User", regInsn(decodePkg::OP_R2, 5'd5, 5'd31, 5'd7, 5'd9, decodePkg::FN_STX,
			1'b1), 32'hB800_0000, decodePkg::MODE_USER, 1'b0, 1'b0, 6'd32, 6'd7, 6'd9, 6'd5,
			6'b000110, 32'h0);
		addRow("r2Super", regInsn(decodePkg::OP_R2, 5'd31, 5'd0, 5'd31, 5'd31,
			decodePkg::FN_STX, 1'b0), 32'hB800_0000, decodePkg::MODE_SUPER, 1'b1, 1'b0, 6'd0,
			6'd33, 6'd33, 6'd33, 6'b100010, 32'h0);
		addRow("shlHyper", regInsn(decodePkg::OP_SHIFT, 5'd0, 5'd4, 5'd31, 5'd0,
			decodePkg::FN_SHL, 1'b1), 32'h8000_0000, decodePkg::MODE_HYPER, 1'b0, 1'b0, 6'd4,
			6'd34, 6'd0, 6'd0, 6'b001100, 32'h0);
		addRow("shriMachine", regInsn(decodePkg::OP_SHIFT, 5'd3, 5'd31, 5'd19, 5'd2,
			decodePkg::FN_SHRI, 1'b0), 32'h8000_0000, decodePkg::MODE_MACHINE, 1'b0, 1'b0,
			6'd35, 6'd0, 6'd2, 6'd3, 6'b010011, 32'd19);
		// Rc slot and rcN bit are both set here and must still decode to zero
		addRow("addiNeg", immInsn(decodePkg::OP_ADDI, 5'd31, 5'd31, 15'h6021), 32'h0,
			decodePkg::MODE_USER, 1'b1, 1'b0, 6'd32, 6'd0, 6'd0, 6'd32, 6'b011011, 32'hFFFF_E021);
		addRow("addsiPos", immInsn(decodePkg::OP_ADDSI, 5'd6, 5'd2, 15'h1234), 32'h0,
			decodePkg::MODE_SUPER, 1'b0, 1'b0, 6'd2, 6'd0, 6'd6, 6'd6, 6'b010011, 32'h1234);
		addRow("orsiNeg", immInsn(decodePkg::OP_ORSI, 5'd31, 5'd1, 15'h7FFF), 32'h0,
			decodePkg::MODE_HYPER, 1'b0, 1'b0, 6'd1, 6'd0, 6'd34, 6'd34, 6'b010111, 32'hFFFF_FFFF);
		addRow("ldoPos", immInsn(decodePkg::OP_LDO, 5'd8, 5'd31, 15'h0155), 32'h0,
			decodePkg::MODE_MACHINE, 1'b0, 1'b0, 6'd35, 6'd0, 6'd0, 6'd8, 6'b011011, 32'h155);
		addRow("stbNeg", immInsn(decodePkg::OP_STB, 5'd31, 5'd3, 15'h6000), 32'h0,
			decodePkg::MODE_SUPER, 1'b1, 1'b0, 6'd3, 6'd0, 6'd33, 6'd0, 6'b010101, 32'hFFFF_E000);
		addRow("stoPos", immInsn(decodePkg::OP_STO, 5'd10, 5'd0, 15'h0007), 32'h0,
			decodePkg::MODE_USER, 1'b0, 1'b0, 6'd0, 6'd0, 6'd10, 6'd0, 6'b110001, 32'h7);
		addRow("stctxHyper", regInsn(decodePkg::OP_STX, 5'd9, 5'd5, 5'd6, 5'd31,
			decodePkg::FN_STCTX, 1'b1), 32'h8000_0F80, decodePkg::MODE_HYPER, 1'b0, 1'b0, 6'd5,
			6'd6, 6'd34, 6'd0, 6'b000000, 32'h0);
		addRow("stxMachine", regInsn(decodePkg::OP_STX, 5'd0, 5'd7, 5'd31, 5'd12,
			decodePkg::FN_STX, 1'b1), 32'h8000_0F80, decodePkg::MODE_MACHINE, 1'b0, 1'b0, 6'd7,
			6'd35, 6'd12, 6'd0, 6'b000100, 32'h0);
		// Never decoded, so its expected columns stay zero
		addRow("flushAddi", immInsn(decodePkg::OP_ADDI, 5'd1, 5'd2, 15'h0003), 32'h0,
			decodePkg::MODE_USER, 1'b0, 1'b1, 6'd0, 6'd0, 6'd0, 6'd0, 6'b000000, 32'h0);
		addRow("nopAfterFlush", regInsn(decodePkg::OP_NOP, 5'd0, 5'd11, 5'd0, 5'd0,
			decodePkg::FN_STX, 1'b0), 32'hB83E_0F80, decodePkg::MODE_USER, 1'b1, 1'b0, 6'd11,
			6'd0, 6'd0, 6'd0, 6'b011000, 32'h0);
	endtask

	// ========================================================================
	// Random bits from a Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
	// ========================================================================

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic randomBits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | int'(lfsrState[0]);
		end
	endtask

	// One LFSR step per don't-care bit of the row
	task automatic fillDontCare(input int i, output logic [31:0] w);
		w = rInsn[i];
		for (int b = 0; b < 32; b++)
		begin
			if (rDc[i][b])
			begin
				lfsrState = lfsrNext(lfsrState);
				w[b] = lfsrState[0];
			end
		end
	endtask

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic abortRun();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic checkAreg(input string name, input string what,
		input logic [decodePkg::AREG_W-1:0] exp, input logic [decodePkg::AREG_W-1:0] act);
		if (act !== exp)
		begin
			$display("ERR %s %s expected %0d actual %0d", name, what, exp, act);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input string what, input logic exp,
		input logic act);
		if (act !== exp)
		begin
			$display("ERR %s %s expected %b actual %b", name, what, exp, act);
			abortRun();
		end
	endtask

	task automatic checkImm(input string name, input logic [decodePkg::IMM_W-1:0] exp,
		input logic [decodePkg::IMM_W-1:0] act);
		if (act !== exp)
		begin
			$display("ERR %s imm expected %h actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkValid(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR %s decValid expected %b actual %b", name, exp, act);
			abortRun();
		end
	endtask

	// Row -1 stands for the all-zero state right after reset
	task automatic checkOutputs(input string name, input int idx);
		logic [decodePkg::AREG_W-1:0] eRa, eRb, eRc, eRt;
		logic [5:0] f;
		logic [decodePkg::IMM_W-1:0] eImm;
		eRa = '0;
		eRb = '0;
		eRc = '0;
		eRt = '0;
		f = '0;
		eImm = '0;
		if (idx >= 0)
		begin
			eRa = rRa[idx];
			eRb = rRb[idx];
			eRc = rRc[idx];
			eRt = rRt[idx];
			f = rFlags[idx];
			eImm = rImm[idx];
		end
		checkAreg(name, "ra", eRa, ra);
		checkFlag(name, "raz", f[5], raz);
		checkAreg(name, "rb", eRb, rb);
		checkFlag(name, "rbz", f[4], rbz);
		checkAreg(name, "rc", eRc, rc);
		checkFlag(name, "rcz", f[3], rcz);
		checkFlag(name, "rcn", f[2], rcn);
		checkAreg(name, "rt", eRt, rt);
		checkFlag(name, "rtWe", f[1], rtWe);
		checkImm(name, eImm, imm);
		checkFlag(name, "hasImm", f[0], hasImm);
	endtask

	// ========================================================================
	// Row sequencing
	// ========================================================================

	task automatic waitDecValid(input string name, output int waited);
		waited = 0;
		while (waited == 0 || (!decValid && waited < 8))
		begin
			@(negedge clk);
			waited++;
		end
		if (!decValid)
		begin
			$display("%s never raised decValid within %0d cycles", name, waited);
			abortRun();
		end
	endtask

	// Issue one row alone, with an optional random stall or a flush behind it
	task automatic runRow(input int i);
		logic [31:0] w;
		int n;
		int waited;
		@(negedge clk);
		fillDontCare(i, w);
		insn = w;
		om = rOm[i];
		insValid = 1'b1;
		@(negedge clk);
		insValid = 1'b0;
		if (rFlush[i])
		begin
			// The row sits in stage 1 now, so the flush has to kill it there
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
			repeat (3)
			begin
				checkValid(rName[i], 1'b0, decValid);
				checkOutputs(rName[i], prevIdx);
				@(negedge clk);
			end
		end
		else
		begin
			if (rStall[i])
			begin
				randomBits(2, n);
				stall = 1'b1;
				repeat (n + 1)
				begin
					@(negedge clk);
					checkValid(rName[i], 1'b0, decValid);
					checkOutputs(rName[i], prevIdx);
				end
				stall = 1'b0;
			end
			waitDecValid(rName[i], waited);
			// One edge after stage 1 is released, two edges after insValid
			if (waited != 1)
			begin
				$display("ERR %s latency expected 1 actual %0d", rName[i], waited);
				abortRun();
			end
			checkOutputs(rName[i], i);
			prevIdx = i;
		end
	endtask

	// Every decodable row back to back, each checked exactly two edges later
	task automatic streamRows();
		int order[$];
		logic [31:0] w;
		for (int i = 0; i < rName.size(); i++)
		begin
			if (!rFlush[i])
				order.push_back(i);
		end
		for (int k = 0; k < order.size() + 2; k++)
		begin
			@(negedge clk);
			if (k >= 2)
			begin
				checkValid({"b2b ", rName[order[k-2]]}, 1'b1, decValid);
				checkOutputs({"b2b ", rName[order[k-2]]}, order[k-2]);
			end
			if (k < order.size())
			begin
				fillDontCare(order[k], w);
				insn = w;
				om = rOm[order[k]];
				insValid = 1'b1;
			end
			else
				insValid = 1'b0;
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		insValid = 1'b0;
		insn = '0;
		om = decodePkg::MODE_USER;
		stall = 1'b0;
		flush = 1'b0;
		buildTable();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		checkValid("reset", 1'b0, decValid);
		checkOutputs("reset", -1);
		for (int i = 0; i < rName.size(); i++)
			runRow(i);
		streamRows();
		$display("NO ERRORS");
		$finish;
	end

	// The limit allows forty cycles per row on top of the reset time
	initial
	begin
		int limit;
		#1;
		limit = rName.size() * 40 + 16;
		repeat (limit) @(posedge clk);
		$display("Timeout after %0d cycles, the decode sequence did not finish", limit);
		abortRun();
	end

endmodule

`default_nettype wire

/* decode.f */
common/decodePkg.sv
decode/decodeCtrl.sv
decode/decodeRab.sv
decode/decodeRc.sv
decode/decodeRt.sv
decode/decodeImm.sv
decode/decodeTop.sv
verif/decode_assertions.sv
verif/decodeTb.sv

/* runSim.sh */
#!/bin/sh
# Compile and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decode.f --top-module decodeTb -o decodeSim

# The log decides the verdict, tee keeps a fatal exit from stopping the script early
./obj_dir/decodeSim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
echo "Simulation passed"
